// File: Makefile
VERILATOR ?= verilator
TOP       ?= gcn_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
hw/gcn_pkg.sv
hw/gcn_ctrl.sv
hw/adj_builder.sv
hw/feat_aggregate.sv
hw/transform_accum.sv
hw/argmax_select.sv
hw/gcn_top.sv
bench/gcn_asserts.sv
bench/gcn_tb.sv

// File: bench/gcn_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module gcn_asserts
    import gcn_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              rd_en,
    input logic [ADDR_W-1:0] rd_addr,
    input logic              y_valid,
    input logic              done
);

    // address stream has no gaps
    addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && $past(rd_en) |-> rd_addr == $past(rd_addr) + 1'b1)
        else $error("rd_addr did not step by one between reads");

    y_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        y_valid |=> !y_valid)
        else $error("y_valid stayed high for more than one cycle");

    // no read may still be in the pipeline while done is high
    read_not_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !rd_en && !$past(rd_en) && !$past(rd_en, 2) && !$past(rd_en, PIPE_DEPTH))
        else $error("done high while a read was still in flight");

endmodule

bind gcn_ctrl gcn_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .y_valid (y_valid),
    .done    (done)
);

`default_nettype wire

// File: bench/gcn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gcn_tb
    import gcn_pkg::*;
();

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 16;
    localparam int DONE_TIMEOUT = 300;
    localparam int RUN_CYCLES   = 109;
    localparam int HOLD_CYCLES  = 4;
    localparam int MID_START    = 40;
    localparam int NUM_ROWS     = 8;
    localparam int SEED         = 92203;

    // one stimulus row
    // expected vector is ignored for random data
    typedef struct packed {
        coo_t       edges;
        logic [1:0] fav_class;
        logic       tie;
        logic       rand_data;
        logic       mid_start;
        class_vec_t expected;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              start;
    coo_t              coo_edges;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    rd_data_t          rd_data = '0;
    class_vec_t        y;
    logic              y_valid;
    logic              done;

    row_t        table_rows [NUM_ROWS];
    feat_col_t   feat_mem [NUM_FEATS];
    weight_row_t wt_mem [NUM_FEATS];

    int checks      = 0;
    int value_errs  = 0;
    int timeouts    = 0;
    bit timed_out   = 1'b0;
    int addr_errs   = 0;
    int next_addr   = 0;
    int total_reads = 0;
    int y_pulses    = 0;
    bit pend_en     = 1'b0;
    int pend_addr   = 0;

    gcn_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .coo_edges (coo_edges),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .y         (y),
        .y_valid   (y_valid),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory model and read monitor
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        // answer the read of the previous cycle
        if (pend_en && pend_addr < NUM_FEATS) begin
            rd_data.feat   = feat_mem[pend_addr];
            rd_data.weight = wt_mem[pend_addr];
        end
        if (rd_en) begin
            assert (int'(rd_addr) == next_addr) else begin
                addr_errs++;
                $display("Fail %0t: read address %0d, expected %0d",
                         $time, rd_addr, next_addr);
            end
            next_addr++;
            total_reads++;
        end else begin
            next_addr = 0;
        end
        if (y_valid) begin
            y_pulses++;
        end
        pend_en   = rd_en;
        pend_addr = int'(rd_addr);
    end

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            value_errs++;
            $display("Fail %0t: %s", $time, what);
        end
    endtask

    function automatic edge_t edge_of(input int src, input int dst);
        edge_t e;
        e.src = node_id_t'(src);
        e.dst = node_id_t'(dst);
        return e;
    endfunction

    // ids 0 to 7 so that empty slots and id 7 show up too
    function automatic coo_t random_edges();
        coo_t edges;
        for (int e = 0; e < NUM_EDGES; e++) begin
            edges[e] = edge_of($urandom_range(7, 0), $urandom_range(7, 0));
        end
        return edges;
    endfunction

    task automatic set_row(input int idx, input coo_t edges, input int fav, input bit tie,
                           input bit rnd, input bit mid, input class_vec_t expected);
        table_rows[idx].edges     = edges;
        table_rows[idx].fav_class = 2'(fav);
        table_rows[idx].tie       = tie;
        table_rows[idx].rand_data = rnd;
        table_rows[idx].mid_start = mid;
        table_rows[idx].expected  = expected;
    endtask

    // edge slot 5 and node 5 come first in each literal
    task automatic build_table();
        set_row(0, {edge_of(0, 0), edge_of(0, 0), edge_of(0, 0),
                    edge_of(0, 0), edge_of(0, 0), edge_of(1, 2)},
                2, 1'b0, 1'b0, 1'b0, {2'd0, 2'd0, 2'd0, 2'd0, 2'd2, 2'd2});
        // same graph padded with empty slots, id 7 and duplicates
        set_row(1, {edge_of(0, 0), edge_of(1, 2), edge_of(2, 1),
                    edge_of(7, 3), edge_of(0, 3), edge_of(1, 2)},
                2, 1'b0, 1'b0, 1'b1, {2'd0, 2'd0, 2'd0, 2'd0, 2'd2, 2'd2});
        set_row(2, {edge_of(0, 0), edge_of(0, 0), edge_of(0, 0),
                    edge_of(0, 0), edge_of(5, 6), edge_of(4, 4)},
                1, 1'b0, 1'b0, 1'b0, {2'd1, 2'd1, 2'd1, 2'd0, 2'd0, 2'd0});
        // classes 1 and 2 tied on top
        set_row(3, {edge_of(0, 0), edge_of(0, 0), edge_of(0, 0),
                    edge_of(0, 0), edge_of(3, 6), edge_of(1, 3)},
                1, 1'b1, 1'b0, 1'b0, {2'd1, 2'd0, 2'd0, 2'd1, 2'd0, 2'd1});
        // ring over all six nodes
        set_row(4, {edge_of(6, 1), edge_of(5, 6), edge_of(4, 5),
                    edge_of(3, 4), edge_of(2, 3), edge_of(1, 2)},
                0, 1'b0, 1'b1, 1'b0, '0);
        set_row(5, random_edges(), 0, 1'b0, 1'b1, 1'b0, '0);
        set_row(6, random_edges(), 0, 1'b0, 1'b1, 1'b1, '0);
        set_row(7, random_edges(), 0, 1'b0, 1'b1, 1'b0, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory contents and reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic fill_memory(input row_t row);
        int other;
        int fav;
        for (int a = 0; a < NUM_FEATS; a++) begin
            for (int m = 0; m < NUM_NODES; m++) begin
                if (row.rand_data) begin
                    feat_mem[a][m] = BW'($urandom_range(31, 0));
                end else begin
                    feat_mem[a][m] = BW'(1 + (a + (a >> 4) + m) % 29);
                end
            end
            // favoured weight always above the others
            other = (a + (a >> 3)) % 8;
            fav   = other + 8 + a % 7;
            for (int c = 0; c < NUM_CLASSES; c++) begin
                if (row.rand_data) begin
                    wt_mem[a][c] = BW'($urandom_range(31, 0));
                end else if (c == int'(row.fav_class)
                             || (row.tie && c == int'(row.fav_class) + 1)) begin
                    wt_mem[a][c] = BW'(fav);
                end else begin
                    wt_mem[a][c] = BW'(other);
                end
            end
        end
    endtask

    function automatic class_vec_t reference_classes(input coo_t edges);
        logic [NUM_NODES-1:0][NUM_NODES-1:0] nbr;
        longint     score [NUM_NODES][NUM_CLASSES];
        int         src;
        int         dst;
        int         sum;
        int         best;
        class_vec_t result;
        nbr = '0;
        for (int e = 0; e < NUM_EDGES; e++) begin
            src = int'(edges[e].src);
            dst = int'(edges[e].dst);
            if (src >= 1 && src <= NUM_NODES && dst >= 1 && dst <= NUM_NODES) begin
                nbr[src-1][dst-1] = 1'b1;
                nbr[dst-1][src-1] = 1'b1;
            end
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                score[n][c] = 0;
            end
        end
        for (int a = 0; a < NUM_FEATS; a++) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                sum = 0;
                for (int m = 0; m < NUM_NODES; m++) begin
                    if (nbr[n][m]) begin
                        sum += int'(feat_mem[a][m]);
                    end
                end
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    score[n][c] += longint'(sum) * longint'(wt_mem[a][c]);
                end
            end
        end
        // lowest class wins a tie
        for (int n = 0; n < NUM_NODES; n++) begin
            best = 0;
            for (int c = 1; c < NUM_CLASSES; c++) begin
                if (score[n][c] > score[n][best]) begin
                    best = c;
                end
            end
            result[n] = CLASS_W'(best);
        end
        return result;
    endfunction

    task automatic run_row(input int idx);
        row_t       row;
        class_vec_t expected;
        int         cycles;
        int         reads_before;
        int         pulses_before;
        row = table_rows[idx];
        fill_memory(row);
        if (row.rand_data) begin
            expected = reference_classes(row.edges);
        end else begin
            expected = row.expected;
        end
        reads_before  = total_reads;
        pulses_before = y_pulses;
        start     = 1'b1;
        coo_edges = row.edges;
        cycles    = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            // a start while streaming must be dropped
            start     = row.mid_start && cycles == MID_START;
            coo_edges = start ? ~row.edges : '0;
        end while (!done && cycles < DONE_TIMEOUT);
        if (!done) begin
            $display("timeout: done did not rise within %0d cycles in row %0d",
                     DONE_TIMEOUT, idx);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            expect_true(cycles == RUN_CYCLES,
                        $sformatf("row %0d done after %0d cycles", idx, cycles));
            expect_true(y_valid, $sformatf("row %0d y_valid low with done", idx));
            expect_true(y == expected,
                        $sformatf("row %0d y %h, expected %h", idx, y, expected));
            repeat (HOLD_CYCLES) begin
                @(posedge clk);
                #1;
                expect_true(done, $sformatf("row %0d done fell before next start", idx));
            end
            expect_true(total_reads - reads_before == NUM_FEATS,
                        $sformatf("row %0d made %0d reads", idx, total_reads - reads_before));
            expect_true(y_pulses - pulses_before == 1,
                        $sformatf("row %0d gave %0d y_valid pulses", idx,
                                  y_pulses - pulses_before));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        coo_edges = '0;
        void'($urandom(SEED));
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_true(!rd_en && !y_valid && !done, "rd_en, y_valid or done high after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!timed_out) begin
                run_row(r);
            end
        end
        $display("checks %0d, value errors %0d, address errors %0d, timeouts %0d",
                 checks, value_errs, addr_errs, timeouts);
        if (value_errs == 0 && addr_errs == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/adj_builder.sv
`timescale 1ns/1ps
`default_nettype none

module adj_builder
    import gcn_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  coo_t       coo_edges,
    input  logic       edge_en,
    input  logic [2:0] edge_idx,
    output adj_mat_t   adj
);

    coo_t  coo_r;
    edge_t cur_edge;
    logic  edge_ok;

    always_ff @(posedge clk) begin
        if (start) begin
            coo_r <= coo_edges;
        end
    end

    assign cur_edge = coo_r[edge_idx];

    // ids 0 and 7 are dropped
    assign edge_ok = cur_edge.src >= node_id_t'(1)
                  && cur_edge.src <= node_id_t'(NUM_NODES)
                  && cur_edge.dst >= node_id_t'(1)
                  && cur_edge.dst <= node_id_t'(NUM_NODES);

    ////////////////////////////////////////////////////////////////////////////
    // symmetric merge, one edge per cycle
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj <= '0;
        end else if (start) begin
            adj <= '0;
        end else if (edge_en && edge_ok) begin
            // a self-loop hits the same bit twice
            adj[cur_edge.src - 1'b1][cur_edge.dst - 1'b1] <= 1'b1;
            adj[cur_edge.dst - 1'b1][cur_edge.src - 1'b1] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/argmax_select.sv
`timescale 1ns/1ps
`default_nettype none

module argmax_select
    import gcn_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  score_mat_t         scores,
    input  logic               scan_en,
    input  logic [CLASS_W-1:0] scan_class,
    output class_vec_t         y
);

    logic [NUM_NODES-1:0][SCORE_W-1:0] best;
    logic [NUM_NODES-1:0]              take;

    // class 0 seeds the search, later classes must win outright
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            take[n] = (scan_class == '0) || (scores[n][scan_class] > best[n]);
        end
    end

    // running maximum per node
    always_ff @(posedge clk) begin
        if (scan_en) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (take[n]) begin
                    best[n] <= scores[n][scan_class];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (scan_en) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (take[n]) begin
                    y[n] <= scan_class;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/feat_aggregate.sv
`timescale 1ns/1ps
`default_nettype none

module feat_aggregate
    import gcn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  adj_mat_t    adj,
    input  logic        data_valid,
    input  rd_data_t    rd_data,
    output ag_vec_t     ag,
    output weight_row_t weight,
    output logic        ag_valid
);

    ag_vec_t ag_next;

    // neighbour sum of the current column, per node
    always_comb begin
        ag_next = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int m = 0; m < NUM_NODES; m++) begin
                if (adj[n][m]) begin
                    ag_next[n] = ag_next[n] + AG_W'(rd_data.feat[m]);
                end
            end
        end
    end

    // weight row follows its column one stage down
    always_ff @(posedge clk) begin
        if (data_valid) begin
            ag     <= ag_next;
            weight <= rd_data.weight;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ag_valid <= 1'b0;
        end else begin
            ag_valid <= data_valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/gcn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gcn_ctrl
    import gcn_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               edge_en,
    output logic [2:0]         edge_idx,
    output logic               rd_en,
    output logic [ADDR_W-1:0]  rd_addr,
    output logic               data_valid,
    output logic               clear,
    output logic               scan_en,
    output logic [CLASS_W-1:0] scan_class,
    output logic               y_valid,
    output logic               done
);

    typedef enum logic [2:0] {
        ph_idle,
        ph_adj,
        ph_stream,
        ph_drain,
        ph_scan,
        ph_done
    } phase_t;

    phase_t     phase;
    logic [1:0] drain_cnt;
    logic       last_edge;
    logic       last_addr;
    logic       last_drain;
    logic       last_scan;

    // start is only taken when idle or finished
    assign clear = start && (phase == ph_idle || phase == ph_done);

    assign last_edge  = edge_idx == 3'(NUM_EDGES - 1);
    assign last_addr  = rd_addr == ADDR_W'(NUM_FEATS - 1);
    assign last_drain = drain_cnt == 2'(PIPE_DEPTH - 1);
    assign last_scan  = scan_class == CLASS_W'(NUM_CLASSES - 1);

    assign edge_en = phase == ph_adj;
    assign rd_en   = phase == ph_stream;
    assign scan_en = phase == ph_scan;
    assign done    = phase == ph_done;

    ////////////////////////////////////////////////////////////////////////////
    // phase sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ph_idle;
        end else begin
            case (phase)
                ph_idle, ph_done: if (clear) phase <= ph_adj;
                ph_adj:           if (last_edge) phase <= ph_stream;
                ph_stream:        if (last_addr) phase <= ph_drain;
                ph_drain:         if (last_drain) phase <= ph_scan;
                ph_scan:          if (last_scan) phase <= ph_done;
                default:          phase <= ph_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // per-phase counters, each back at zero when its phase ends
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_idx   <= '0;
            rd_addr    <= '0;
            drain_cnt  <= '0;
            scan_class <= '0;
            data_valid <= 1'b0;
            y_valid    <= 1'b0;
        end else begin
            if (edge_en) begin
                edge_idx <= last_edge ? 3'd0 : edge_idx + 3'd1;
            end
            if (rd_en) begin
                rd_addr <= last_addr ? '0 : rd_addr + 1'b1;
            end
            if (phase == ph_drain) begin
                drain_cnt <= last_drain ? 2'd0 : drain_cnt + 2'd1;
            end
            if (scan_en) begin
                scan_class <= last_scan ? '0 : scan_class + 1'b1;
            end
            // memory answers one cycle after rd_en
            data_valid <= rd_en;
            // argmax result lands one cycle after the last scan step
            y_valid    <= scan_en && last_scan;
        end
    end

endmodule

`default_nettype wire

// File: hw/gcn_pkg.sv
`default_nettype none

package gcn_pkg;

    // graph and data sizes
    localparam int NUM_NODES   = 6;
    localparam int NUM_EDGES   = 6;
    localparam int NUM_FEATS   = 96;
    localparam int NUM_CLASSES = 3;

    // datapath widths
    localparam int BW        = 5;
    localparam int NODE_ID_W = 3;
    localparam int ADDR_W    = 7;
    localparam int AG_W      = 8;
    localparam int SCORE_W   = 21;
    localparam int CLASS_W   = 2;

    // last read address to last accumulate
    localparam int PIPE_DEPTH = 3;

    // 0 marks an empty slot, 1 to 6 name nodes
    typedef logic [NODE_ID_W-1:0] node_id_t;

    typedef struct packed {
        node_id_t src;
        node_id_t dst;
    } edge_t;

    typedef edge_t [NUM_EDGES-1:0] coo_t;

    typedef logic [NUM_NODES-1:0][NUM_NODES-1:0] adj_mat_t;
    typedef logic [NUM_NODES-1:0][BW-1:0] feat_col_t;
    typedef logic [NUM_CLASSES-1:0][BW-1:0] weight_row_t;

    // one memory word, feature column above weight row
    typedef struct packed {
        feat_col_t   feat;
        weight_row_t weight;
    } rd_data_t;

    typedef logic [NUM_NODES-1:0][AG_W-1:0] ag_vec_t;
    typedef logic [NUM_NODES-1:0][NUM_CLASSES-1:0][SCORE_W-1:0] score_mat_t;
    typedef logic [NUM_NODES-1:0][CLASS_W-1:0] class_vec_t;

endpackage

`default_nettype wire

// File: hw/gcn_top.sv
`timescale 1ns/1ps
`default_nettype none

module gcn_top
    import gcn_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  coo_t              coo_edges,
    output logic              rd_en,
    output logic [ADDR_W-1:0] rd_addr,
    input  rd_data_t          rd_data,
    output class_vec_t        y,
    output logic              y_valid,
    output logic              done
);

    // control strobes
    logic               edge_en;
    logic [2:0]         edge_idx;
    logic               data_valid;
    logic               clear;
    logic               scan_en;
    logic [CLASS_W-1:0] scan_class;

    // datapath
    adj_mat_t    adj;
    ag_vec_t     ag;
    weight_row_t weight;
    logic        ag_valid;
    score_mat_t  scores;

    gcn_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .edge_en    (edge_en),
        .edge_idx   (edge_idx),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .data_valid (data_valid),
        .clear      (clear),
        .scan_en    (scan_en),
        .scan_class (scan_class),
        .y_valid    (y_valid),
        .done       (done)
    );

    // capture only on an accepted start
    adj_builder u_adj (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (clear),
        .coo_edges (coo_edges),
        .edge_en   (edge_en),
        .edge_idx  (edge_idx),
        .adj       (adj)
    );

    feat_aggregate u_agg (
        .clk        (clk),
        .rst_n      (rst_n),
        .adj        (adj),
        .data_valid (data_valid),
        .rd_data    (rd_data),
        .ag         (ag),
        .weight     (weight),
        .ag_valid   (ag_valid)
    );

    transform_accum u_acc (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .ag       (ag),
        .weight   (weight),
        .ag_valid (ag_valid),
        .scores   (scores)
    );

    argmax_select u_argmax (
        .clk        (clk),
        .rst_n      (rst_n),
        .scores     (scores),
        .scan_en    (scan_en),
        .scan_class (scan_class),
        .y          (y)
    );

endmodule

`default_nettype wire

// File: hw/transform_accum.sv
`timescale 1ns/1ps
`default_nettype none

module transform_accum
    import gcn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  ag_vec_t     ag,
    input  weight_row_t weight,
    input  logic        ag_valid,
    output score_mat_t  scores
);

    score_mat_t scores_next;

    ////////////////////////////////////////////////////////////////////////////
    // one multiply-add per node and class
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        scores_next = scores;
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                // 8x5 product, far below the score width
                scores_next[n][c] = scores[n][c]
                                  + SCORE_W'(ag[n]) * SCORE_W'(weight[c]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '0;
        end else if (clear) begin
            // new run starts from zero
            scores <= '0;
        end else if (ag_valid) begin
            scores <= scores_next;
        end
    end

endmodule

`default_nettype wire
